//--- design/color_bar_pkg.sv
package color_bar_pkg;

	typedef logic [31:0] pixel_t; // r, g, b bytes, low byte zero
	typedef logic [17:0] addr_t;
	typedef logic [15:0] coord_t;

	localparam int band_count = 3;
	localparam int max_segments = 11;

	// palette
	localparam pixel_t light_gray  = 32'hc0c0c000;
	localparam pixel_t yellow      = 32'hc0c00000;
	localparam pixel_t light_blue  = 32'h00c0c000;
	localparam pixel_t green       = 32'h00c00000;
	localparam pixel_t purple      = 32'hc000c000;
	localparam pixel_t red         = 32'hc0000000;
	localparam pixel_t blue        = 32'h0000c000;
	localparam pixel_t gray        = 32'h13131300;
	localparam pixel_t dark_blue   = 32'h00214c00;
	localparam pixel_t white       = 32'hffffff00;
	localparam pixel_t dark_purple = 32'h32006a00;
	localparam pixel_t mid_gray1   = 32'h09090900;
	localparam pixel_t mid_gray2   = 32'h1d1d1d00;

	// bars per band, top to bottom
	localparam int band_segments [band_count] = '{8, 8, 11};

	// bar widths in 1/32 of the image width, each row sums to 32
	localparam int band_units [band_count][max_segments] = '{
		'{4, 4, 4, 4, 4, 4, 4, 4, 0, 0, 0},
		'{4, 4, 4, 4, 4, 4, 4, 4, 0, 0, 0},
		'{4, 4, 4, 4, 1, 1, 1, 1, 4, 4, 4}
	};

	localparam pixel_t band_colors [band_count][max_segments] = '{
		'{
			light_gray, yellow, light_blue, green,
			purple, red, blue, white,
			32'h0, 32'h0, 32'h0
		},
		'{
			blue, gray, purple, gray,
			light_blue, gray, light_gray, gray,
			32'h0, 32'h0, 32'h0
		},
		'{
			dark_blue, white, dark_purple, gray,
			mid_gray1, gray, mid_gray2, mid_gray1, // the four narrow bars
			gray, light_gray, gray
		}
	};

	// band heights in quarters of the image height
	localparam int band_row_units [band_count] = '{2, 1, 1};

endpackage

//--- design/raster_scanner.sv
`timescale 1ns/1ps

module raster_scanner #(
	parameter int img_width = 320,
	parameter int img_height = 240
) (
	input logic clk,
	input logic reset,
	input logic pause,
	input logic enable,
	input color_bar_pkg::addr_t starting_address,
	input logic frame_written,
	output color_bar_pkg::coord_t scan_x,
	output color_bar_pkg::coord_t scan_y,
	output color_bar_pkg::addr_t scan_addr,
	output logic scan_valid,
	output logic scan_last,
	output logic done
);

	typedef enum logic [1:0] {
		idle,
		scanning,
		draining,
		finished
	} state_t;

	localparam color_bar_pkg::coord_t last_x = color_bar_pkg::coord_t'(img_width - 1);
	localparam color_bar_pkg::coord_t last_y = color_bar_pkg::coord_t'(img_height - 1);

	state_t state;
	color_bar_pkg::coord_t x_cnt;
	color_bar_pkg::coord_t y_cnt;
	color_bar_pkg::addr_t addr_cnt;
	logic at_last;

	assign at_last = (x_cnt == last_x) && (y_cnt == last_y);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			scan_valid <= 1'b0;
			scan_last <= 1'b0;
			done <= 1'b0;
		end else if (!pause) begin
			case (state)
				idle: begin
					if (enable)
						state <= scanning;
				end
				scanning: begin
					scan_valid <= 1'b1;
					scan_last <= at_last;
					if (at_last)
						state <= draining;
				end
				draining: begin
					scan_valid <= 1'b0;
					scan_last <= 1'b0;
					if (frame_written) begin // last pixel is in memory
						done <= 1'b1;
						state <= finished;
					end
				end
				finished: begin
					if (!enable) begin // re-arm
						done <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// coordinate and address counters, qualified by scan_valid
	always_ff @(posedge clk) begin
		if (!pause) begin
			if (state == idle && enable) begin
				addr_cnt <= starting_address;
				x_cnt <= '0;
				y_cnt <= '0;
			end else if (state == scanning) begin
				scan_x <= x_cnt;
				scan_y <= y_cnt;
				scan_addr <= addr_cnt;
				addr_cnt <= addr_cnt + 1'b1; // wraps in 18 bits
				if (x_cnt == last_x) begin
					x_cnt <= '0;
					y_cnt <= y_cnt + 1'b1;
				end else begin
					x_cnt <= x_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- design/band_painter.sv
`timescale 1ns/1ps

module band_painter #(
	parameter int img_width = 320,
	parameter int img_height = 240,
	parameter int band = 0
) (
	input logic clk,
	input logic reset,
	input logic pause,
	input color_bar_pkg::coord_t scan_x,
	input color_bar_pkg::coord_t scan_y,
	input logic scan_valid,
	output logic hit,
	output color_bar_pkg::pixel_t color
);

	typedef logic [color_bar_pkg::max_segments-1:0][15:0] edge_vec_t;

	function automatic int rows_above(int b);
		int sum;
		sum = 0;
		for (int i = 0; i < b; i++)
			sum += color_bar_pkg::band_row_units[i];
		return sum;
	endfunction

	// exclusive right edge of every bar, in pixels
	function automatic edge_vec_t calc_edges(int unit);
		edge_vec_t edges;
		int sum;
		sum = 0;
		for (int s = 0; s < color_bar_pkg::max_segments; s++) begin
			sum += color_bar_pkg::band_units[band][s];
			edges[s] = 16'(sum * unit);
		end
		return edges;
	endfunction

	localparam int row_unit = img_height / 4;
	localparam int first_row = row_unit * rows_above(band);
	localparam int last_row = first_row + row_unit * color_bar_pkg::band_row_units[band] - 1;
	localparam int seg_count = color_bar_pkg::band_segments[band];
	localparam edge_vec_t bar_edge = calc_edges(img_width / 32);

	logic in_band;
	color_bar_pkg::pixel_t bar_color;

	assign in_band = scan_valid && (int'(scan_y) >= first_row) && (int'(scan_y) <= last_row);

	// first bar whose right edge lies beyond scan_x
	always_comb begin
		logic found;
		found = 1'b0;
		bar_color = color_bar_pkg::band_colors[band][0];
		for (int s = 0; s < color_bar_pkg::max_segments; s++) begin
			if (!found && s < seg_count && scan_x < bar_edge[s]) begin
				bar_color = color_bar_pkg::band_colors[band][s];
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			hit <= 1'b0;
		else if (!pause)
			hit <= in_band;
	end

	always_ff @(posedge clk) begin
		if (!pause && in_band)
			color <= bar_color;
	end

endmodule

//--- design/frame_writer.sv
`timescale 1ns/1ps

module frame_writer (
	input logic clk,
	input logic reset,
	input logic pause,
	input color_bar_pkg::addr_t scan_addr,
	input logic scan_last,
	input logic [color_bar_pkg::band_count-1:0] hit,
	input color_bar_pkg::pixel_t color [color_bar_pkg::band_count],
	output color_bar_pkg::pixel_t data_write,
	output color_bar_pkg::addr_t addr,
	output logic wren,
	output logic frame_written
);

	color_bar_pkg::addr_t addr_d; // lines up with painter outputs
	logic last_d;
	color_bar_pkg::pixel_t sel_color;
	logic any_hit;
	logic wren_q;
	logic written_q;

	assign any_hit = |hit;

	// bands do not overlap so at most one hit is set
	always_comb begin
		sel_color = '0;
		for (int b = 0; b < color_bar_pkg::band_count; b++) begin
			if (hit[b])
				sel_color = color[b];
		end
	end

	always_ff @(posedge clk) begin
		if (!pause)
			addr_d <= scan_addr;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			last_d <= 1'b0;
			wren_q <= 1'b0;
			written_q <= 1'b0;
			data_write <= '0;
			addr <= '0;
		end else if (!pause) begin
			last_d <= scan_last;
			wren_q <= any_hit;
			written_q <= any_hit && last_d;
			if (any_hit) begin
				data_write <= sel_color;
				addr <= addr_d;
			end
		end
	end

	// a held write only counts once pause drops
	assign wren = wren_q && !pause;
	assign frame_written = written_q && !pause;

endmodule

//--- design/color_bar_gen.sv
`timescale 1ns/1ps

module color_bar_gen #(
	parameter int img_width = 320,
	parameter int img_height = 240
) (
	input logic clk,
	input logic reset,
	input logic pause,
	input logic enable,
	input color_bar_pkg::addr_t starting_address,
	output color_bar_pkg::pixel_t data_write,
	output color_bar_pkg::addr_t addr,
	output logic wren,
	output logic done
);

	color_bar_pkg::coord_t scan_x;
	color_bar_pkg::coord_t scan_y;
	color_bar_pkg::addr_t scan_addr;
	logic scan_valid;
	logic scan_last;
	logic frame_written;
	logic [color_bar_pkg::band_count-1:0] hit;
	color_bar_pkg::pixel_t color [color_bar_pkg::band_count];

	raster_scanner #(
		.img_width(img_width),
		.img_height(img_height)
	) i_scanner (
		.clk(clk),
		.reset(reset),
		.pause(pause),
		.enable(enable),
		.starting_address(starting_address),
		.frame_written(frame_written),
		.scan_x(scan_x),
		.scan_y(scan_y),
		.scan_addr(scan_addr),
		.scan_valid(scan_valid),
		.scan_last(scan_last),
		.done(done)
	);

	// one painter per horizontal band
	for (genvar i = 0; i < color_bar_pkg::band_count; i++) begin : g_band
		band_painter #(
			.img_width(img_width),
			.img_height(img_height),
			.band(i)
		) i_painter (
			.clk(clk),
			.reset(reset),
			.pause(pause),
			.scan_x(scan_x),
			.scan_y(scan_y),
			.scan_valid(scan_valid),
			.hit(hit[i]),
			.color(color[i])
		);
	end

	frame_writer i_writer (
		.clk(clk),
		.reset(reset),
		.pause(pause),
		.scan_addr(scan_addr),
		.scan_last(scan_last),
		.hit(hit),
		.color(color),
		.data_write(data_write),
		.addr(addr),
		.wren(wren),
		.frame_written(frame_written)
	);

endmodule

//--- tests/color_bar_tb.sv
`timescale 1ns/1ps

module color_bar_tb;

	localparam int img_width = 64;
	localparam int img_height = 16;
	localparam int frame_pixels = img_width * img_height;
	// the sampling edge and three pipeline edges come before the edge that sees the write
	localparam int first_write_edge = 5;
	localparam int timeout_cycles = 4 * 2048 + 500;

	// bar colours left to right for each band
	localparam color_bar_pkg::pixel_t top_colors [8] = '{
		color_bar_pkg::light_gray, color_bar_pkg::yellow,
		color_bar_pkg::light_blue, color_bar_pkg::green,
		color_bar_pkg::purple, color_bar_pkg::red,
		color_bar_pkg::blue, color_bar_pkg::white
	};
	localparam color_bar_pkg::pixel_t mid_colors [8] = '{
		color_bar_pkg::blue, color_bar_pkg::gray,
		color_bar_pkg::purple, color_bar_pkg::gray,
		color_bar_pkg::light_blue, color_bar_pkg::gray,
		color_bar_pkg::light_gray, color_bar_pkg::gray
	};
	localparam color_bar_pkg::pixel_t low_colors [11] = '{
		color_bar_pkg::dark_blue, color_bar_pkg::white,
		color_bar_pkg::dark_purple, color_bar_pkg::gray,
		color_bar_pkg::mid_gray1, color_bar_pkg::gray,
		color_bar_pkg::mid_gray2, color_bar_pkg::mid_gray1,
		color_bar_pkg::gray, color_bar_pkg::light_gray,
		color_bar_pkg::gray
	};

	logic clk;
	logic reset;
	logic pause;
	logic enable;
	color_bar_pkg::addr_t starting_address;
	color_bar_pkg::pixel_t data_write;
	color_bar_pkg::addr_t addr;
	logic wren;
	logic done;

	int value_errors;
	int other_errors;
	int cycle_count;
	logic [15:0] lfsr_state;
	color_bar_pkg::addr_t got_addr [$];

	color_bar_gen #(
		.img_width(img_width),
		.img_height(img_height)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.pause(pause),
		.enable(enable),
		.starting_address(starting_address),
		.data_write(data_write),
		.addr(addr),
		.wren(wren),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			value_errors++;
			$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic report_failure(input string what);
		other_errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	// 16 bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic color_bar_pkg::pixel_t expected_color(int x, int y);
		int u;
		u = x / (img_width / 32); // column in 1/32 of the width
		if (y < img_height / 2)
			return top_colors[u / 4];
		if (y < img_height * 3 / 4)
			return mid_colors[u / 4];
		if (u < 16)
			return low_colors[u / 4];
		if (u < 20)
			return low_colors[u - 12]; // narrow grey bars
		return low_colors[8 + (u - 20) / 4];
	endfunction

	// starts a frame and checks every write until the last one
	task automatic capture_frame(input color_bar_pkg::addr_t start, input logic use_pause,
		input logic check_latency);
		int n;
		int k;
		int limit;
		logic w;
		logic p;
		color_bar_pkg::addr_t a;
		color_bar_pkg::pixel_t dw;
		got_addr.delete();
		n = 0;
		k = 0;
		limit = 3 * frame_pixels + 100;
		@(posedge clk);
		enable <= 1'b1;
		starting_address <= start;
		if (use_pause)
			pause <= next_random_bit();
		while (k < frame_pixels && n < limit) begin
			@(posedge clk);
			n++;
			w = wren;
			p = pause;
			a = addr;
			dw = data_write;
			if (w && p)
				report_failure("write enable high in a paused cycle");
			if (done)
				report_failure("done high before the last write");
			if (w) begin
				if (check_latency && k == 0 && n != first_write_edge)
					report_failure($sformatf("first write seen %0d edges after enable, not %0d",
						n, first_write_edge));
				compare_value("addr", a, color_bar_pkg::addr_t'(start + k));
				compare_value("data_write", dw, expected_color(k % img_width, k / img_width));
				got_addr.push_back(a);
				k++;
				if (k == 1)
					starting_address <= start ^ 18'h2aaaa; // must already be latched
			end else if (k > 0 && !p) begin
				report_failure($sformatf("gap in the write stream after write %0d", k - 1));
			end
			if (use_pause && k < frame_pixels)
				pause <= next_random_bit();
			else
				pause <= 1'b0;
		end
		if (k < frame_pixels)
			report_failure($sformatf("only %0d of %0d writes arrived", k, frame_pixels));
		@(posedge clk);
		compare_value("done", done, 32'd1);
		compare_value("wren", wren, 32'd0);
	endtask

	// done is held while enable is high and drops one edge after enable falls
	task automatic release_done(input int hold);
		repeat (hold) begin
			@(posedge clk);
			compare_value("done", done, 32'd1);
			if (wren)
				report_failure("write issued while done was held");
		end
		enable <= 1'b0;
		@(posedge clk);
		compare_value("done", done, 32'd1);
		@(posedge clk);
		compare_value("done", done, 32'd0);
		compare_value("wren", wren, 32'd0);
	endtask

	task automatic reset_state();
		repeat (3) begin
			@(posedge clk);
			compare_value("wren", wren, 32'd0);
			compare_value("done", done, 32'd0);
			compare_value("addr", addr, 32'd0);
			compare_value("data_write", data_write, 32'd0);
		end
	endtask

	task automatic full_frame();
		capture_frame(18'h00100, 1'b0, 1'b1);
		compare_value("write count", got_addr.size(), frame_pixels);
	endtask

	task automatic done_handshake();
		release_done(20);
	endtask

	task automatic wrapped_frame();
		capture_frame(18'h3ff80, 1'b0, 1'b1);
		compare_value("write count", got_addr.size(), frame_pixels);
		if (got_addr.size() > 128)
			compare_value("addr", got_addr[128], 32'd0); // first address past the wrap
		release_done(5);
	endtask

	// same start as the unpaused frame so every write must match the same model values
	task automatic paused_frame();
		capture_frame(18'h00100, 1'b1, 1'b0);
		compare_value("write count", got_addr.size(), frame_pixels);
		release_done(5);
	endtask

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		pause = 1'b0;
		enable = 1'b0;
		starting_address = '0;
		value_errors = 0;
		other_errors = 0;
		lfsr_state = 16'd52136;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		reset_state();
		full_frame();
		done_handshake();
		wrapped_frame();
		paused_frame();

		repeat (2) @(posedge clk);
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- sim.f
design/color_bar_pkg.sv
design/raster_scanner.sv
design/band_painter.sv
design/frame_writer.sv
design/color_bar_gen.sv
tests/color_bar_tb.sv

//--- Bender.yml
package:
  name: color_bar_gen

sources:
  - design/color_bar_pkg.sv
  - design/raster_scanner.sv
  - design/band_painter.sv
  - design/frame_writer.sv
  - design/color_bar_gen.sv
  - target: test
    files:
      - tests/color_bar_tb.sv
